// ==== common/csr_params.svh ====
////////////////////////////////////////////////////////////
// CSR unit options
////////////////////////////////////////////////////////////

`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Data width of the core
`define XLEN 32

// mtvec value after reset
// Trap handler starts at the base of main memory
`define RESET_VECTOR 32'h8000_0000

// Compressed instruction support
// 0 keeps mepc 4-byte aligned
// 1 would allow 2-byte aligned mepc
`define C_SUPPORTED 1'b0

`endif

// ==== common/csrPkg.sv ====
////////////////////////////////////////////////////////////
// CSR package
// Privilege mode type and CSR addresses
////////////////////////////////////////////////////////////

`default_nettype none

package csrPkg;

  // Privilege levels present in this core
  // Supervisor level (1) is not implemented
  typedef enum logic [1:0] {
    privUser    = 2'd0,
    privMachine = 2'd3
  } privMode;

  ////////////////////////////////////////////////////////////
  // Machine trap setup and handling
  localparam logic [11:0] adrMstatus       = 12'h300;
  localparam logic [11:0] adrMtvec         = 12'h305;
  localparam logic [11:0] adrMcounteren    = 12'h306;
  localparam logic [11:0] adrMcountinhibit = 12'h320;
  localparam logic [11:0] adrMscratch      = 12'h340;
  localparam logic [11:0] adrMepc          = 12'h341;
  localparam logic [11:0] adrMcause        = 12'h342;
  localparam logic [11:0] adrMtval         = 12'h343;

  ////////////////////////////////////////////////////////////
  // Machine counters, read/write
  localparam logic [11:0] adrMcycle        = 12'hB00;
  localparam logic [11:0] adrMinstret      = 12'hB02;

  // User read-only counter aliases
  localparam logic [11:0] adrCycle         = 12'hC00;
  localparam logic [11:0] adrInstret       = 12'hC02;

  // Floating-point status
  localparam logic [11:0] adrFflags        = 12'h001;
  localparam logic [11:0] adrFrm           = 12'h002;
  localparam logic [11:0] adrFcsr          = 12'h003;

endpackage

`default_nettype wire

// ==== common/csrAccessIf.sv ====
////////////////////////////////////////////////////////////
// CSR access bus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

// Decoded CSR request, shared by every register block
interface csrAccessIf;

  // Address from instr[31:20]
  logic [11:0]        adr;
  // Final value after replace, set or clear
  logic [`XLEN-1:0]   writeVal;
  // Write strobe for machine-level registers
  logic               mWrite;
  // Write strobe for user-level registers
  logic               uWrite;
  // Current privilege of the instruction
  csrPkg::privMode    priv;

  // Front end side
  modport source (output adr, writeVal, mWrite, uWrite, priv);

  // Register block side
  modport sink (input adr, writeVal, mWrite, uWrite, priv);

endinterface

`default_nettype wire

// ==== csr/csrMachine.sv ====
////////////////////////////////////////////////////////////
// Machine trap registers
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csrMachine (
  input  logic               clk,
  input  logic               reset,
  csrAccessIf.sink           bus,
  input  logic               trap,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   cause,
  input  logic [`XLEN-1:0]   faultValue,
  output logic [`XLEN-1:0]   readVal,
  output logic               illegal,
  output logic [`XLEN-1:0]   mepc,
  output logic [`XLEN-1:0]   mtvec
);

  logic [`XLEN-1:0] mscratch, mcause, mtval;
  logic [`XLEN-1:0] epcRaw, epcNext;
  logic             writeMtvec, writeMscratch, writeMepc, writeMcause, writeMtval;

  // Write strobes per register
  assign writeMtvec    = bus.mWrite && (bus.adr == csrPkg::adrMtvec);
  assign writeMscratch = bus.mWrite && (bus.adr == csrPkg::adrMscratch);
  assign writeMepc     = bus.mWrite && (bus.adr == csrPkg::adrMepc);
  assign writeMcause   = bus.mWrite && (bus.adr == csrPkg::adrMcause);
  assign writeMtval    = bus.mWrite && (bus.adr == csrPkg::adrMtval);

  // Trap pc or software value, then forced to instruction alignment
  assign epcRaw  = trap ? pc : bus.writeVal;
  assign epcNext = `C_SUPPORTED ? {epcRaw[`XLEN-1:1], 1'b0} : {epcRaw[`XLEN-1:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // Registers

  always_ff @(posedge clk) begin
    if (reset) begin
      mtvec    <= `RESET_VECTOR;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      // Bit 1 is reserved in the mode field
      if (writeMtvec)
        mtvec <= {bus.writeVal[`XLEN-1:2], 1'b0, bus.writeVal[0]};
      if (writeMscratch)
        mscratch <= bus.writeVal;
      // Trap capture overrides any software write
      if (trap || writeMepc)
        mepc <= epcNext;
      if (trap)
        mcause <= cause;
      else if (writeMcause)
        mcause <= bus.writeVal;
      if (trap)
        mtval <= faultValue;
      else if (writeMtval)
        mtval <= bus.writeVal;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux

  always_comb begin
    readVal = '0;
    illegal = 1'b0;
    case (bus.adr)
      csrPkg::adrMtvec:    readVal = mtvec;
      csrPkg::adrMscratch: readVal = mscratch;
      csrPkg::adrMepc:     readVal = mepc;
      csrPkg::adrMcause:   readVal = mcause;
      csrPkg::adrMtval:    readVal = mtval;
      default:             illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== csr/csrStatus.sv ====
////////////////////////////////////////////////////////////
// Machine status register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csrStatus (
  input  logic               clk,
  input  logic               reset,
  csrAccessIf.sink           bus,
  input  logic               trap,
  input  logic               mret,
  output logic [`XLEN-1:0]   readVal,
  output logic               illegal,
  output logic               statusMie,
  output logic [1:0]         statusMpp
);

  logic            mie, mpie;
  csrPkg::privMode mpp;
  logic            writeStatus, mppLegal;

  assign writeStatus = bus.mWrite && (bus.adr == csrPkg::adrMstatus);

  // MPP is WARL, only user and machine are kept
  assign mppLegal = (bus.writeVal[12:11] == csrPkg::privUser) ||
                    (bus.writeVal[12:11] == csrPkg::privMachine);

  // Trap first, then mret, then software write
  always_ff @(posedge clk) begin
    if (reset) begin
      mie  <= 1'b0;
      mpie <= 1'b0;
      mpp  <= csrPkg::privMachine;
    end else if (trap) begin
      mpie <= mie;
      mie  <= 1'b0;
      mpp  <= bus.priv;
    end else if (mret) begin
      mie  <= mpie;
      mpie <= 1'b1;
      mpp  <= csrPkg::privUser;
    end else if (writeStatus) begin
      mie  <= bus.writeVal[3];
      mpie <= bus.writeVal[7];
      if (mppLegal)
        mpp <= csrPkg::privMode'(bus.writeVal[12:11]);
    end
  end

  assign statusMie = mie;
  assign statusMpp = mpp;

  // MPP at 12:11, MPIE at 7, MIE at 3, the rest reads zero
  assign illegal = (bus.adr != csrPkg::adrMstatus);
  assign readVal = illegal ? '0 :
    {{(`XLEN-13){1'b0}}, mpp, 3'b000, mpie, 3'b000, mie, 3'b000};

endmodule

`default_nettype wire

// ==== csr/csrCounters.sv ====
////////////////////////////////////////////////////////////
// Cycle and retired instruction counters
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csrCounters (
  input  logic               clk,
  input  logic               reset,
  csrAccessIf.sink           bus,
  input  logic               instrValid,
  output logic [`XLEN-1:0]   readVal,
  output logic               illegal
);

  logic [`XLEN-1:0] mcycle, minstret;
  // Only bits 0 (cycle) and 2 (instret) exist
  logic             inhibitCy, inhibitIr;
  logic             enableCy, enableIr;
  logic             isMachine;

  assign isMachine = (bus.priv == csrPkg::privMachine);

  always_ff @(posedge clk) begin
    if (reset) begin
      mcycle    <= '0;
      minstret  <= '0;
      inhibitCy <= 1'b0;
      inhibitIr <= 1'b0;
      enableCy  <= 1'b0;
      enableIr  <= 1'b0;
    end else begin
      // Explicit write beats the increment
      if (bus.mWrite && (bus.adr == csrPkg::adrMcycle))
        mcycle <= bus.writeVal;
      else if (!inhibitCy)
        mcycle <= mcycle + 1'b1;
      if (bus.mWrite && (bus.adr == csrPkg::adrMinstret))
        minstret <= bus.writeVal;
      else if (instrValid && !inhibitIr)
        minstret <= minstret + 1'b1;
      if (bus.mWrite && (bus.adr == csrPkg::adrMcountinhibit)) begin
        inhibitCy <= bus.writeVal[0];
        inhibitIr <= bus.writeVal[2];
      end
      if (bus.mWrite && (bus.adr == csrPkg::adrMcounteren)) begin
        enableCy <= bus.writeVal[0];
        enableIr <= bus.writeVal[2];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read mux

  // User aliases need the matching mcounteren bit
  always_comb begin
    readVal = '0;
    illegal = 1'b0;
    case (bus.adr)
      csrPkg::adrMcycle:        readVal = mcycle;
      csrPkg::adrMinstret:      readVal = minstret;
      csrPkg::adrMcountinhibit: readVal = {{(`XLEN-3){1'b0}}, inhibitIr, 1'b0, inhibitCy};
      csrPkg::adrMcounteren:    readVal = {{(`XLEN-3){1'b0}}, enableIr, 1'b0, enableCy};
      csrPkg::adrCycle: begin
        illegal = !(isMachine || enableCy);
        readVal = illegal ? '0 : mcycle;
      end
      csrPkg::adrInstret: begin
        illegal = !(isMachine || enableIr);
        readVal = illegal ? '0 : minstret;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== csr/csrFloat.sv ====
////////////////////////////////////////////////////////////
// Floating-point CSRs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csrFloat (
  input  logic               clk,
  input  logic               reset,
  csrAccessIf.sink           bus,
  input  logic [4:0]         setFflags,
  output logic [`XLEN-1:0]   readVal,
  output logic               illegal,
  output logic [2:0]         frm
);

  logic [4:0] fflags, flagsBase;
  logic       writeFlags, writeFrm, writeFcsr;

  // fcsr writes both fields at once
  assign writeFcsr  = bus.uWrite && (bus.adr == csrPkg::adrFcsr);
  assign writeFlags = writeFcsr || (bus.uWrite && (bus.adr == csrPkg::adrFflags));
  assign writeFrm   = bus.uWrite && (bus.adr == csrPkg::adrFrm);

  // Flags sit in bits 4:0 for both fflags and fcsr
  // New exception flags still accumulate on a write
  assign flagsBase = writeFlags ? bus.writeVal[4:0] : fflags;

  always_ff @(posedge clk) begin
    if (reset) begin
      fflags <= '0;
      frm    <= '0;
    end else begin
      fflags <= flagsBase | setFflags;
      if (writeFcsr)
        frm <= bus.writeVal[7:5];
      else if (writeFrm)
        frm <= bus.writeVal[2:0];
    end
  end

  always_comb begin
    readVal = '0;
    illegal = 1'b0;
    case (bus.adr)
      csrPkg::adrFflags: readVal = {{(`XLEN-5){1'b0}}, fflags};
      csrPkg::adrFrm:    readVal = {{(`XLEN-3){1'b0}}, frm};
      csrPkg::adrFcsr:   readVal = {{(`XLEN-8){1'b0}}, frm, fflags};
      default:           illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== csr/csr.sv ====
////////////////////////////////////////////////////////////
// CSR unit top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "csr_params.svh"

module csr (
  input  logic               clk,
  input  logic               reset,
  input  logic [31:0]        instr,
  input  logic [`XLEN-1:0]   pc,
  input  logic [`XLEN-1:0]   srcA,
  input  logic               csrAccess,
  input  logic               trap,
  input  logic               mret,
  input  logic [`XLEN-1:0]   cause,
  input  logic [`XLEN-1:0]   faultValue,
  input  logic               instrValid,
  input  logic [4:0]         setFflags,
  input  logic [1:0]         priv,
  output logic [`XLEN-1:0]   readVal,
  output logic               illegalAccess,
  output logic [`XLEN-1:0]   mepc,
  output logic [`XLEN-1:0]   mtvec,
  output logic               statusMie,
  output logic [1:0]         statusMpp,
  output logic [2:0]         frm
);

  logic [`XLEN-1:0] csrSrc;
  logic [`XLEN-1:0] machineRead, statusRead, counterRead, floatRead;
  logic             machineIllegal, statusIllegal, counterIllegal, floatIllegal;
  logic             lowPrivilege;

  csrAccessIf access ();

  ////////////////////////////////////////////////////////////
  // Request decode

  assign access.adr  = instr[31:20];
  assign access.priv = csrPkg::privMode'(priv);

  // Register source or zero-extended uimm for the I forms
  assign csrSrc = instr[14] ? {{(`XLEN-5){1'b0}}, instr[19:15]} : srcA;

  // funct3[1:0] picks replace, set or clear
  // Modify against the merged old value
  always_comb begin
    case (instr[13:12])
      2'b01:   access.writeVal = csrSrc;
      2'b10:   access.writeVal = readVal | csrSrc;
      2'b11:   access.writeVal = readVal & ~csrSrc;
      default: access.writeVal = readVal;
    endcase
  end

  // Machine registers only take writes from machine mode
  assign access.mWrite = csrAccess && (access.priv == csrPkg::privMachine);
  assign access.uWrite = csrAccess;

  ////////////////////////////////////////////////////////////
  // Register blocks

  csrMachine machineRegs (
    .clk        (clk),
    .reset      (reset),
    .bus        (access),
    .trap       (trap),
    .pc         (pc),
    .cause      (cause),
    .faultValue (faultValue),
    .readVal    (machineRead),
    .illegal    (machineIllegal),
    .mepc       (mepc),
    .mtvec      (mtvec)
  );

  csrStatus statusReg (
    .clk       (clk),
    .reset     (reset),
    .bus       (access),
    .trap      (trap),
    .mret      (mret),
    .readVal   (statusRead),
    .illegal   (statusIllegal),
    .statusMie (statusMie),
    .statusMpp (statusMpp)
  );

  csrCounters counters (
    .clk        (clk),
    .reset      (reset),
    .bus        (access),
    .instrValid (instrValid),
    .readVal    (counterRead),
    .illegal    (counterIllegal)
  );

  csrFloat floatRegs (
    .clk       (clk),
    .reset     (reset),
    .bus       (access),
    .setFflags (setFflags),
    .readVal   (floatRead),
    .illegal   (floatIllegal),
    .frm       (frm)
  );

  ////////////////////////////////////////////////////////////
  // Read merge and access check

  // Blocks return zero when not addressed, so OR is enough
  assign readVal = machineRead | statusRead | counterRead | floatRead;

  // Address bits 9:8 hold the lowest privilege allowed
  assign lowPrivilege = (access.adr[9:8] == 2'b11) && (access.priv == csrPkg::privUser);

  assign illegalAccess = csrAccess &&
    ((machineIllegal && statusIllegal && counterIllegal && floatIllegal) || lowPrivilege);

endmodule

`default_nettype wire

// ==== verification/csrTb.sv ====
////////////////////////////////////////////////////////////
// CSR unit testbench
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module csrTb;

  // Trace path is relative to the project root
  localparam string tracePath = "verification/csr_trace.txt";
  // Upper bound on trace lines before the run counts as hung
  localparam int maxSteps = 1000;

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic [31:0] pc;
  logic [31:0] srcA;
  logic        csrAccess;
  logic        trap;
  logic        mret;
  logic [31:0] cause;
  logic [31:0] faultValue;
  logic        instrValid;
  logic [4:0]  setFflags;
  logic [1:0]  priv;

  logic [31:0] readVal;
  logic        illegalAccess;
  logic [31:0] mepc;
  logic [31:0] mtvec;
  logic        statusMie;
  logic [1:0]  statusMpp;
  logic [2:0]  frm;

  // Expected outputs from the current trace line
  logic [31:0] expReadVal;
  logic        expIllegal;
  logic [31:0] expMepc;
  logic [31:0] expMtvec;
  logic        expMie;
  logic [1:0]  expMpp;
  logic [2:0]  expFrm;

  csr dut_i (
    .clk           (clk),
    .reset         (reset),
    .instr         (instr),
    .pc            (pc),
    .srcA          (srcA),
    .csrAccess     (csrAccess),
    .trap          (trap),
    .mret          (mret),
    .cause         (cause),
    .faultValue    (faultValue),
    .instrValid    (instrValid),
    .setFflags     (setFflags),
    .priv          (priv),
    .readVal       (readVal),
    .illegalAccess (illegalAccess),
    .mepc          (mepc),
    .mtvec         (mtvec),
    .statusMie     (statusMie),
    .statusMpp     (statusMpp),
    .frm           (frm)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Failure handling

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected)
    else
      abortRun($sformatf("Error: time %0t, %s expected %h, actual %h",
                         $time, name, expected, actual));
  endtask

  // All top-level outputs against the trace line
  task automatic compareOutputs();
    checkValue("readVal", readVal, expReadVal);
    checkValue("illegalAccess", 32'(illegalAccess), 32'(expIllegal));
    checkValue("mepc", mepc, expMepc);
    checkValue("mtvec", mtvec, expMtvec);
    checkValue("statusMie", 32'(statusMie), 32'(expMie));
    checkValue("statusMpp", 32'(statusMpp), 32'(expMpp));
    checkValue("frm", 32'(frm), 32'(expFrm));
  endtask

  ////////////////////////////////////////////////////////////
  // Trace replay

  initial begin : runTrace
    int    fd;
    int    fields;
    int    steps;
    int    vectors;
    string line;
    clk        = 1'b0;
    reset      = 1'b1;
    instr      = '0;
    pc         = '0;
    srcA       = '0;
    csrAccess  = 1'b0;
    trap       = 1'b0;
    mret       = 1'b0;
    cause      = '0;
    faultValue = '0;
    instrValid = 1'b0;
    setFflags  = '0;
    priv       = 2'd3;
    steps      = 0;
    vectors    = 0;
    fd = $fopen(tracePath, "r");
    if (fd == 0)
      abortRun($sformatf("Cannot open trace file %s", tracePath));
    // Reset over five rising edges, then drive 1 ns after the edge
    repeat (5) @(posedge clk);
    #1;
    while (!$feof(fd) && steps < maxSteps) begin
      line = "";
      void'($fgets(line, fd));
      steps++;
      // Skip column notes and blank lines
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      fields = $sscanf(line,
        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        reset, instr, pc, srcA, csrAccess, trap, mret, cause, faultValue,
        instrValid, setFflags, priv,
        expReadVal, expIllegal, expMepc, expMtvec, expMie, expMpp, expFrm);
      if (fields != 19)
        abortRun($sformatf("Trace line %0d is incomplete, %0d of 19 fields read",
                           steps, fields));
      vectors++;
      // Sample 1 ns before the next rising edge
      #2;
      compareOutputs();
      @(posedge clk);
      #1;
    end
    if (!$feof(fd))
      abortRun($sformatf("Trace did not end within %0d lines", maxSteps));
    else if (vectors == 0)
      abortRun("Trace file holds no vectors");
    else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/csr_trace.txt ====
# reset instr pc srcA csrAccess trap mret cause faultValue instrValid setFflags priv
# then expected readVal illegalAccess mepc mtvec statusMie statusMpp frm
0 305020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  80000000 0 00000000 80000000 0 3 0
0 300020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00001800 0 00000000 80000000 0 3 0
0 340290F3 00000000 A5A500FF 1 0 0 00000000 00000000 0 00 3  00000000 0 00000000 80000000 0 3 0
0 3402A0F3 00000000 0F000F00 1 0 0 00000000 00000000 0 00 3  A5A500FF 0 00000000 80000000 0 3 0
0 3402B0F3 00000000 0000F0F0 1 0 0 00000000 00000000 0 00 3  AFA50FFF 0 00000000 80000000 0 3 0
0 340AD0F3 00000000 FFFFFFFF 1 0 0 00000000 00000000 0 00 3  AFA50F0F 0 00000000 80000000 0 3 0
0 340560F3 00000000 FFFFFFFF 1 0 0 00000000 00000000 0 00 3  00000015 0 00000000 80000000 0 3 0
0 3401F0F3 00000000 FFFFFFFF 1 0 0 00000000 00000000 0 00 3  0000001F 0 00000000 80000000 0 3 0
0 340020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  0000001C 0 00000000 80000000 0 3 0
0 300290F3 00000000 00000008 1 0 0 00000000 00000000 0 00 3  00001800 0 00000000 80000000 0 3 0
0 00000000 00001236 00000000 0 1 0 00000002 DEADBEEF 0 00 3  00000000 0 00000000 80000000 1 0 0
0 342020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000002 0 00001234 80000000 0 3 0
0 343020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  DEADBEEF 0 00001234 80000000 0 3 0
0 341020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00001234 0 00001234 80000000 0 3 0
0 300020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00001880 0 00001234 80000000 0 3 0
0 00000000 00000000 00000000 0 0 1 00000000 00000000 0 00 3  00000000 0 00001234 80000000 0 3 0
0 300020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000088 0 00001234 80000000 1 0 0
0 340290F3 00000000 12345678 1 0 0 00000000 00000000 0 00 0  0000001C 1 00001234 80000000 1 0 0
0 340020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  0000001C 0 00001234 80000000 1 0 0
0 7C0020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000000 1 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 0  00000000 1 00001234 80000000 1 0 0
0 306290F3 00000000 00000001 1 0 0 00000000 00000000 0 00 3  00000000 0 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 0  00000016 0 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000017 0 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000018 0 00001234 80000000 1 0 0
0 C02020F3 00000000 00000000 1 0 0 00000000 00000000 1 00 3  00000000 0 00001234 80000000 1 0 0
0 C02020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000001 0 00001234 80000000 1 0 0
0 C02020F3 00000000 00000000 1 0 0 00000000 00000000 1 00 3  00000001 0 00001234 80000000 1 0 0
0 320290F3 00000000 00000005 1 0 0 00000000 00000000 1 00 3  00000000 0 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 1 00 3  0000001D 0 00001234 80000000 1 0 0
0 C02020F3 00000000 00000000 1 0 0 00000000 00000000 1 00 3  00000003 0 00001234 80000000 1 0 0
0 B00290F3 00000000 00001000 1 0 0 00000000 00000000 0 00 3  0000001D 0 00001234 80000000 1 0 0
0 320290F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00000005 0 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00001000 0 00001234 80000000 1 0 0
0 C00020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  00001001 0 00001234 80000000 1 0 0
0 00000000 00000000 00000000 0 0 0 00000000 00000000 0 01 3  00000000 0 00001234 80000000 1 0 0
0 001020F3 00000000 00000000 1 0 0 00000000 00000000 0 04 3  00000001 0 00001234 80000000 1 0 0
0 003290F3 00000000 00000088 1 0 0 00000000 00000000 0 02 3  00000005 0 00001234 80000000 1 0 0
0 003020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 3  0000008A 0 00001234 80000000 1 0 4
0 002290F3 00000000 00000003 1 0 0 00000000 00000000 0 00 0  00000004 0 00001234 80000000 1 0 4
0 002020F3 00000000 00000000 1 0 0 00000000 00000000 0 00 0  00000003 0 00001234 80000000 1 0 3

// ==== build.f ====
+incdir+common
common/csrPkg.sv
common/csrAccessIf.sv
csr/csrMachine.sv
csr/csrStatus.sv
csr/csrCounters.sv
csr/csrFloat.sv
csr/csr.sv
verification/csrTb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the CSR unit with its testbench and run the simulation
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module csrTb -f build.f \
  && ./obj_dir/VcsrTb \
  || { echo "Simulation did not pass"; exit 1; }

exit 0
